//--- Makefile
# Verilator flow for the convolution core, every variable can be set on the command line

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_conv_engine
RTL_TOP    ?= conv_engine
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= TESTBENCH PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_EXE := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# the status comes from grep, so a run without the pass line fails
sim: $(SIM_EXE)
	./$(SIM_EXE) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
conv_pkg.sv
conv_control.sv
conv_mul_array.sv
conv_acc_array.sv
conv_engine.sv
tb_conv_engine.sv

//--- conv_acc_array.sv
// ----------------------------------------------------------
// accumulators with bypass load, sums wrap at WIDTH_OUT
// WIDTH_OUT must not be smaller than 2*WIDTH_IN
// ----------------------------------------------------------
`timescale 1ns/100ps

module conv_acc_array #(
  parameter int CORES     = 2,
  parameter int UNITS     = 2,
  parameter int WIDTH_IN  = conv_pkg::WIDTH_IN_DEF,
  parameter int WIDTH_OUT = conv_pkg::WIDTH_OUT_DEF
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                acc_en,
  input  logic                                acc_load,
  input  logic                                clken,
  input  logic [CORES*UNITS*2*WIDTH_IN-1:0]   products,
  output logic [CORES*UNITS*WIDTH_OUT-1:0]    sums
);

  localparam int PAIRS  = CORES * UNITS;
  localparam int PROD_W = 2 * WIDTH_IN;

  for (genvar p = 0; p < PAIRS; p++) begin : g_pair
    logic signed [PROD_W-1:0]    prod;
    logic signed [WIDTH_OUT-1:0] prod_ext;
    logic signed [WIDTH_OUT-1:0] sum_q;

    assign prod     = products[p*PROD_W +: PROD_W];
    assign prod_ext = WIDTH_OUT'(prod);  // sign extended

    always_ff @(posedge clk) begin
      if (rst) begin
        sum_q <= '0;
      end else if (clken && acc_en) begin
        if (acc_load) begin
          sum_q <= prod_ext;         // first product of a kernel position
        end else begin
          sum_q <= sum_q + prod_ext; // wraps in two's complement
        end
      end
    end

    assign sums[p*WIDTH_OUT +: WIDTH_OUT] = sum_q;
  end

  // acc_en comes from the control delay line, an X here corrupts every sum
  a_acc_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(acc_en));

endmodule

//--- conv_control.sv
// ----------------------------------------------------------
// control path that clken freezes like the datapath
// delay line depth must equal the multiplier pipeline depth
// ----------------------------------------------------------
`timescale 1ns/100ps

module conv_control #(
  parameter int MUL_DELAY = conv_pkg::MUL_DELAY_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     s_valid,
  input  logic                     s_last,
  input  conv_pkg::conv_user_t     s_user,
  output logic                     mul_en,
  output logic                     acc_en,
  output logic                     acc_load,
  output logic                     m_valid,
  output logic                     m_last,
  output conv_pkg::conv_out_user_t m_user
);
  import conv_pkg::*;

  // one slot of the delay line that follows a beat through the multiplier
  typedef struct packed {
    logic       valid;
    logic       last;
    conv_user_t user;
  } stage_t;

  stage_t     stage_q [MUL_DELAY];
  stage_t     stage_in;
  stage_t     mul_out;  // control aligned with the product
  acc_phase_e phase;

  assign stage_in = '{valid: s_valid, last: s_last, user: s_user};
  assign mul_out  = stage_q[MUL_DELAY-1];

  assign mul_en   = clken;                 // whole pipe stalls together
  assign acc_en   = mul_out.valid;
  assign acc_load = (phase == ACC_FRESH);  // bypass starts a new sum

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MUL_DELAY; i++) begin
        stage_q[i] <= '0;
      end
    end else if (clken) begin
      stage_q[0] <= stage_in;
      for (int i = 1; i < MUL_DELAY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // the beat after acc_last sees ACC_FRESH
  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= ACC_FRESH;
    end else if (clken && acc_en) begin
      phase <= mul_out.user.acc_last ? ACC_FRESH : ACC_ADD;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (clken) begin
      m_valid <= mul_out.valid && mul_out.user.acc_last;  // one beat per closed sum
      m_last  <= mul_out.valid && mul_out.user.acc_last && mul_out.last;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) m_user <= '{tag: mul_out.user.tag};
  end

  // reset must flush the whole delay line and not only its head
  a_no_valid_after_rst: assert property (@(posedge clk) $fell(rst) |=> !m_valid);

  // a frame-last beat has to close a sum so that m_last can carry it
  a_last_closes_sum: assert property (@(posedge clk) disable iff (rst)
    s_valid && clken && s_last |-> s_user.acc_last);

endmodule

//--- conv_engine.sv
// ----------------------------------------------------------
// convolution MAC core, single kernel tap
// clken is the downstream ready and freezes the whole pipe
// ----------------------------------------------------------
`timescale 1ns/100ps

module conv_engine #(
  parameter int CORES     = 2,
  parameter int UNITS     = 2,
  parameter int WIDTH_IN  = conv_pkg::WIDTH_IN_DEF,
  parameter int WIDTH_OUT = conv_pkg::WIDTH_OUT_DEF,
  parameter int MUL_DELAY = conv_pkg::MUL_DELAY_DEF
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             clken,
  input  logic                             s_valid,
  input  logic                             s_last,
  input  conv_pkg::conv_user_t             s_user,
  input  logic [UNITS*WIDTH_IN-1:0]        s_pixels,
  input  logic [CORES*WIDTH_IN-1:0]        s_weights,
  output logic                             s_ready,
  output logic                             m_valid,
  output logic                             m_last,
  output conv_pkg::conv_out_user_t         m_user,
  output logic [CORES*UNITS*WIDTH_OUT-1:0] m_data
);

  logic                              mul_en;
  logic                              acc_en;
  logic                              acc_load;
  logic [CORES*UNITS*2*WIDTH_IN-1:0] products;

  assign s_ready = clken;  // a beat is taken whenever the pipe moves

  conv_control #(
    .MUL_DELAY (MUL_DELAY)
  ) control_i (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .s_valid  (s_valid),
    .s_last   (s_last),
    .s_user   (s_user),
    .mul_en   (mul_en),
    .acc_en   (acc_en),
    .acc_load (acc_load),
    .m_valid  (m_valid),
    .m_last   (m_last),
    .m_user   (m_user)
  );

  conv_mul_array #(
    .CORES     (CORES),
    .UNITS     (UNITS),
    .WIDTH_IN  (WIDTH_IN),
    .MUL_DELAY (MUL_DELAY)
  ) mul_i (
    .clk      (clk),
    .mul_en   (mul_en),
    .pixels   (s_pixels),
    .weights  (s_weights),
    .products (products)
  );

  // sums are valid to the outside only while m_valid is high
  conv_acc_array #(
    .CORES     (CORES),
    .UNITS     (UNITS),
    .WIDTH_IN  (WIDTH_IN),
    .WIDTH_OUT (WIDTH_OUT)
  ) acc_i (
    .clk      (clk),
    .rst      (rst),
    .acc_en   (acc_en),
    .acc_load (acc_load),
    .clken    (clken),
    .products (products),
    .sums     (m_data)
  );

endmodule

//--- conv_mul_array.sv
// ----------------------------------------------------------
// one signed multiplier per core/unit pair without reset
// products are word c*UNITS+u in core-major order
// ----------------------------------------------------------
`timescale 1ns/100ps

module conv_mul_array #(
  parameter int CORES     = 2,
  parameter int UNITS     = 2,
  parameter int WIDTH_IN  = conv_pkg::WIDTH_IN_DEF,
  parameter int MUL_DELAY = conv_pkg::MUL_DELAY_DEF
) (
  input  logic                                clk,
  input  logic                                mul_en,
  input  logic [UNITS*WIDTH_IN-1:0]           pixels,
  input  logic [CORES*WIDTH_IN-1:0]           weights,
  output logic [CORES*UNITS*2*WIDTH_IN-1:0]   products
);

  localparam int PROD_W = 2 * WIDTH_IN;

  for (genvar c = 0; c < CORES; c++) begin : g_core
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      localparam int P = c * UNITS + u;

      logic signed [WIDTH_IN-1:0] pix;
      logic signed [WIDTH_IN-1:0] wgt;
      logic signed [PROD_W-1:0]   pipe_q [MUL_DELAY];

      assign pix = pixels[u*WIDTH_IN +: WIDTH_IN];   // pixel shared by all cores
      assign wgt = weights[c*WIDTH_IN +: WIDTH_IN];  // weight shared by all units

      always_ff @(posedge clk) begin
        if (mul_en) begin
          pipe_q[0] <= PROD_W'(pix) * PROD_W'(wgt);
          for (int s = 1; s < MUL_DELAY; s++) begin
            pipe_q[s] <= pipe_q[s-1];
          end
        end
      end

      assign products[P*PROD_W +: PROD_W] = pipe_q[MUL_DELAY-1];
    end
  end

endmodule

//--- conv_pkg.sv
// ----------------------------------------------------------
// widths and user fields shared by the convolution core
// accumulator width must be at least twice the input width
// ----------------------------------------------------------
package conv_pkg;

  // default datapath sizes
  parameter int WIDTH_IN_DEF  = 8;   // signed pixel and weight word
  parameter int WIDTH_OUT_DEF = 20;  // accumulator word, wraps
  parameter int MUL_DELAY_DEF = 3;   // multiplier pipeline depth

  parameter int TAG_BITS = 4;        // pass-through tag

  // user sideband on the input beat
  typedef struct packed {
    logic                acc_last;  // closes the running sum
    logic [TAG_BITS-1:0] tag;
  } conv_user_t;

  // user sideband on the output beat, acc_last is consumed inside
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
  } conv_out_user_t;

  // whether the next valid product loads or adds
  typedef enum logic {
    ACC_FRESH = 1'b0,
    ACC_ADD   = 1'b1
  } acc_phase_e;

endpackage

//--- conv_stim.txt
// beat count, then one beat per line: valid last acc_last tag px0 px1 w0 w1 exp_tag
// pixels and weights are signed bytes, exp_tag is the output tag of an acc_last beat
2c
1 0 1 1 05 fd 03 fe 1
0 0 0 0 7f 7f 7f 7f 0
1 0 0 2 0c f4 05 fb 0
1 0 0 2 81 22 10 c0 0
1 0 0 2 3a 9c f0 7f 0
1 0 1 2 ee 40 80 11 2
1 0 1 3 09 f7 0b 02 3
1 0 1 4 80 7f 7f 80 4
1 1 1 5 ff 01 ff 01 5
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 0 6 80 7f 80 80 0
1 0 1 6 80 7f 80 80 6
1 0 0 7 64 9c c8 38 0
1 1 1 7 d3 2d 19 e7 7
1 0 1 8 7e 82 02 fe 8

//--- tb_conv_engine.sv
// ----------------------------------------------------------
// testbench for conv_engine at 2 cores, 2 units, 8-bit words
// reads conv_stim.txt, so run it from the project root
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_conv_engine;
  import conv_pkg::*;

  localparam int CORES     = 2;
  localparam int UNITS     = 2;
  localparam int WIDTH_IN  = 8;
  localparam int WIDTH_OUT = 20;
  localparam int MUL_DELAY = 3;
  localparam int DATA_W    = CORES * UNITS * WIDTH_OUT;
  localparam int FIELDS    = 9;    // words per beat in the stim file
  localparam int N_BEATS   = 44;

  localparam int CALM_CYCLES   = 24;  // clken held high while the first beats go in
  localparam int STALL_START   = 30;
  localparam int STALL_LEN     = 8;
  localparam int DRIVE_TIMEOUT = 400;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int IDLE_CYCLES   = 6;

  // one closed sum as the core should deliver it
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic                last;
    logic [TAG_BITS-1:0] tag;
    logic [31:0]         edge_idx;  // enabled edge that took the closing beat
  } exp_out_t;

  logic                      clk;
  logic                      rst;
  logic                      clken;
  logic                      s_valid;
  logic                      s_last;
  conv_user_t                s_user;
  logic [UNITS*WIDTH_IN-1:0] s_pixels;
  logic [CORES*WIDTH_IN-1:0] s_weights;
  logic                      s_ready;
  logic                      m_valid;
  logic                      m_last;
  conv_out_user_t            m_user;
  logic [DATA_W-1:0]         m_data;

  logic [7:0]                  stim_mem [1 + N_BEATS*FIELDS];
  logic signed [WIDTH_OUT-1:0] run_sum [CORES*UNITS];
  exp_out_t                    exp_q [$];
  exp_out_t                    head;
  exp_out_t                    held;      // output seen during a stall
  logic                        held_valid;
  logic                        fresh;     // next valid beat starts a sum
  logic [31:0]                 edge_cnt;
  logic [31:0]                 rnd;
  int                          cur_beat;
  int                          outputs_seen;
  int                          n_closed;

  conv_engine #(
    .CORES     (CORES),
    .UNITS     (UNITS),
    .WIDTH_IN  (WIDTH_IN),
    .WIDTH_OUT (WIDTH_OUT),
    .MUL_DELAY (MUL_DELAY)
  ) conv_engine_i (
    .clk       (clk),
    .rst       (rst),
    .clken     (clken),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_user    (s_user),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_user    (m_user),
    .m_data    (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // adds the accepted beat into the per-pair sums
  task automatic model_beat();
    logic signed [WIDTH_IN-1:0]  pix;
    logic signed [WIDTH_IN-1:0]  wgt;
    logic signed [WIDTH_OUT-1:0] prod;
    exp_out_t                    item;
    item = '0;
    for (int c = 0; c < CORES; c++) begin
      for (int u = 0; u < UNITS; u++) begin
        pix  = s_pixels[u*WIDTH_IN +: WIDTH_IN];
        wgt  = s_weights[c*WIDTH_IN +: WIDTH_IN];
        prod = WIDTH_OUT'(pix) * WIDTH_OUT'(wgt);
        if (fresh) run_sum[c*UNITS+u] = prod;
        else run_sum[c*UNITS+u] = run_sum[c*UNITS+u] + prod;  // wraps at 20 bits
        item.data[(c*UNITS+u)*WIDTH_OUT +: WIDTH_OUT] = run_sum[c*UNITS+u];
      end
    end
    fresh = s_user.acc_last;
    if (s_user.acc_last) begin
      item.last     = s_last;
      item.tag      = stim_mem[1 + cur_beat*FIELDS + 8][TAG_BITS-1:0];
      item.edge_idx = edge_cnt;
      exp_q.push_back(item);
    end
  endtask

  // sampled on the falling edge, everything is settled there
  always @(negedge clk) begin
    if (!rst) begin
      check_value("s_ready", DATA_W'(s_ready), DATA_W'(clken));
      if (held_valid) begin  // a stalled output must stay put
        check_value("m_valid", DATA_W'(m_valid), DATA_W'(1'b1));
        check_value("m_data", m_data, held.data);
        check_value("m_last", DATA_W'(m_last), DATA_W'(held.last));
        check_value("m_user.tag", DATA_W'(m_user.tag), DATA_W'(held.tag));
      end
      if (m_valid && clken) begin
        assert (exp_q.size() > 0) else begin
          $display("output beat appeared with no closed sum pending");
          report_failure();
        end
        head = exp_q.pop_front();
        check_value("m_data", m_data, head.data);
        check_value("m_last", DATA_W'(m_last), DATA_W'(head.last));
        check_value("m_user.tag", DATA_W'(m_user.tag), DATA_W'(head.tag));
        check_value("latency", DATA_W'(edge_cnt - head.edge_idx), DATA_W'(MUL_DELAY + 1));
        outputs_seen++;
      end
      if (s_valid && clken) model_beat();
      held_valid = m_valid && !clken;
      held.data  = m_data;
      held.last  = m_last;
      held.tag   = m_user.tag;
      if (clken) edge_cnt = edge_cnt + 32'd1;
    end
  end

  task automatic drive_beats();
    int   cyc;
    int   base;
    logic en;
    cyc = 0;
    cur_beat = 0;
    while (cur_beat < N_BEATS) begin
      base = 1 + cur_beat*FIELDS;
      rnd  = next_rand(rnd);
      if (cyc < CALM_CYCLES) en = 1'b1;
      else if (cyc >= STALL_START && cyc < STALL_START + STALL_LEN) en = 1'b0;
      else en = (rnd[1:0] != 2'b00);  // high about 3 cycles in 4
      clken     <= en;
      s_valid   <= stim_mem[base][0];
      s_last    <= stim_mem[base+1][0];
      s_user    <= '{acc_last: stim_mem[base+2][0], tag: stim_mem[base+3][TAG_BITS-1:0]};
      s_pixels  <= {stim_mem[base+5], stim_mem[base+4]};
      s_weights <= {stim_mem[base+7], stim_mem[base+6]};
      @(posedge clk);
      if (en) cur_beat++;  // beat taken on this edge
      cyc++;
      if (cyc > DRIVE_TIMEOUT) begin
        $display("timeout: only %0d of %0d input beats accepted", cur_beat, N_BEATS);
        report_failure();
      end
    end
    s_valid <= 1'b0;
    clken   <= 1'b1;
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        $display("timeout: %0d closed sums never left the core", exp_q.size());
        report_failure();
      end
    end
    repeat (MUL_DELAY + 2) @(posedge clk);  // no stray beats afterwards
  endtask

  initial begin
    rst          = 1'b1;
    clken        = 1'b1;
    s_valid      = 1'b0;
    s_last       = 1'b0;
    s_user       = '0;
    s_pixels     = '0;
    s_weights    = '0;
    held_valid   = 1'b0;
    held         = '0;
    fresh        = 1'b1;
    edge_cnt     = '0;
    rnd          = 32'hdae00852;
    cur_beat     = 0;
    outputs_seen = 0;
    n_closed     = 0;
    $readmemh("conv_stim.txt", stim_mem);
    assert (stim_mem[0] == 8'(N_BEATS)) else begin
      $display("stim file announces %0d beats instead of %0d", stim_mem[0], N_BEATS);
      report_failure();
    end
    for (int b = 0; b < N_BEATS; b++) begin
      if (stim_mem[1 + b*FIELDS][0] && stim_mem[3 + b*FIELDS][0]) n_closed++;
    end

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < IDLE_CYCLES; i++) begin  // quiet output before any beat
      @(negedge clk);
      check_value("m_valid", DATA_W'(m_valid), '0);
      check_value("m_last", DATA_W'(m_last), '0);
    end
    @(posedge clk);
    drive_beats();
    drain_outputs();

    if (exp_q.size() == 0 && outputs_seen == n_closed) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("run ended with %0d of %0d closed sums seen", outputs_seen, n_closed);
      report_failure();
    end
  end

endmodule
